/* rtl/cpuPkg.sv */
package cpuPkg;

	// primary opcodes
	typedef enum logic [5:0] {
		opJ      = 6'h02,
		opRtype  = 6'h03,
		opBne    = 6'h04,
		opBeq    = 6'h05,
		opJal    = 6'h07,
		opAddi   = 6'h09,
		opAndi   = 6'h0C,
		opOri    = 6'h0E,
		opLui    = 6'h0F,
		opLw     = 6'h12,
		opLbu    = 6'h22,
		opSb     = 6'h28,
		opSw     = 6'h2B
	} opcodeE;

	// function codes for opRtype
	typedef enum logic [5:0] {
		fnSll    = 6'h00,
		fnSrl    = 6'h02,
		fnJr     = 6'h08,
		fnAdd    = 6'h20,
		fnSub    = 6'h22,
		fnAnd    = 6'h24,
		fnOr     = 6'h25,
		fnNor    = 6'h27,
		fnSlt    = 6'h2A,
		fnSltu   = 6'h2B
	} funcE;

	typedef enum logic [2:0] {
		aluFunc  = 3'd0, // decode from func field
		aluAdd   = 3'd1,
		aluSub   = 3'd2, // compare for branches
		aluAnd   = 3'd3,
		aluOr    = 3'd4
	} aluOpE;

	typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b10} regDestE;
	typedef enum logic {src1Zero = 1'b0, src1Reg = 1'b1} src1E;
	typedef enum logic [1:0] {src2Reg = 2'b00, src2Imm = 2'b01, src2Pc8 = 2'b10} src2E;
	typedef enum logic [1:0] {jmpNone = 2'b00, jmpTarget = 2'b01, jmpReg = 2'b10} jumpE;
	typedef enum logic [1:0] {brNone = 2'b00, brEq = 2'b01, brNe = 2'b10} branchE;
	typedef enum logic [1:0] {srcAlu = 2'b00, srcMem = 2'b01, srcUpper = 2'b10} regSrcE;

	localparam logic [4:0] regRa = 5'd31; // link register for jal

	typedef struct packed {
		opcodeE     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funcE       func;
	} rFormT;

	typedef struct packed {
		opcodeE      opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFormT;

	typedef struct packed {
		opcodeE      opcode;
		logic [25:0] target26;
	} jFormT;

	// one fetched word in three field layouts
	typedef union packed {
		rFormT r;
		iFormT i;
		jFormT j;
	} instrU;

	typedef struct packed {
		aluOpE   aluOp;
		logic    regWrite;
		regDestE regDest;
		src1E    aluSrc1;
		src2E    aluSrc2;
		jumpE    jump;
		branchE  branch;
		regSrcE  regSrc;
		logic    zeroExt;
		logic    memRead;
		logic    memWrite;
		logic    byteAccess;
	} ctrlT;

	// nothing written and no flow change
	localparam ctrlT ctrlIdle = '{
		aluOp:      aluFunc,
		regWrite:   1'b0,
		regDest:    dstRt,
		aluSrc1:    src1Reg,
		aluSrc2:    src2Reg,
		jump:       jmpNone,
		branch:     brNone,
		regSrc:     srcAlu,
		zeroExt:    1'b0,
		memRead:    1'b0,
		memWrite:   1'b0,
		byteAccess: 1'b0
	};

	typedef struct packed {
		logic        valid;
		logic [4:0]  addr;
		logic [31:0] data;
	} wbT;

endpackage

/* rtl/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit (
	input  cpuPkg::instrU instr,
	output cpuPkg::ctrlT  ctrl
);
	import cpuPkg::*;

	always_comb begin
		ctrl = ctrlIdle;
		case (instr.r.opcode)
			opRtype: begin
				ctrl.aluOp   = aluFunc;
				ctrl.aluSrc2 = src2Reg; // rt operand
				case (instr.r.func)
					fnJr: begin
						ctrl.jump = jmpReg;
					end
					fnAdd, fnSub, fnAnd, fnOr, fnNor,
					fnSlt, fnSltu, fnSll, fnSrl: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDest  = dstRd;
					end
					default: ctrl = ctrlIdle; // unknown func
				endcase
			end
			opJ: begin
				ctrl.jump = jmpTarget;
			end
			opJal: begin
				// link value is 0 + (pc+8) through the alu
				ctrl.regWrite = 1'b1;
				ctrl.jump     = jmpTarget;
				ctrl.regDest  = dstRa;
				ctrl.aluSrc1  = src1Zero;
				ctrl.aluSrc2  = src2Pc8;
				ctrl.aluOp    = aluAdd;
			end
			opBeq: begin
				ctrl.aluOp  = aluSub;
				ctrl.branch = brEq;
			end
			opBne: begin
				ctrl.aluOp  = aluSub;
				ctrl.branch = brNe;
			end
			opAddi: begin
				ctrl.aluOp    = aluAdd;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc2  = src2Imm;
			end
			opAndi: begin
				ctrl.aluOp    = aluAnd;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc2  = src2Imm;
				ctrl.zeroExt  = 1'b1;
			end
			opOri: begin
				ctrl.aluOp    = aluOr;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc2  = src2Imm;
				ctrl.zeroExt  = 1'b1;
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.regSrc   = srcUpper; // imm << 16
			end
			opLw, opLbu: begin
				ctrl.aluOp      = aluAdd; // base + offset
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrc2    = src2Imm;
				ctrl.regSrc     = srcMem;
				ctrl.memRead    = 1'b1;
				ctrl.byteAccess = (instr.r.opcode == opLbu);
			end
			opSw, opSb: begin
				ctrl.aluOp      = aluAdd;
				ctrl.aluSrc2    = src2Imm;
				ctrl.memWrite   = 1'b1;
				ctrl.byteAccess = (instr.r.opcode == opSb);
			end
			default: ctrl = ctrlIdle; // unknown opcode
		endcase

		// pc would have two competing sources otherwise
		assert (!(ctrl.jump != jmpNone && ctrl.branch != brNone))
			else $error("controlUnit: jump and branch both active");
	end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/100ps

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	input  logic        wrEn,
	output logic [31:0] rsData,
	output logic [31:0] rtData
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData; // r0 never written
		end
	end

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	// r0 stays zero across every write
	assert property (@(posedge clk) disable iff (!rstN) regs[0] == 32'h0)
		else $error("regFile: r0 = %h", regs[0]);

endmodule

/* rtl/execUnit.sv */
`timescale 1ns/100ps

module execUnit (
	input  cpuPkg::instrU instr,
	input  cpuPkg::ctrlT  ctrl,
	input  logic [31:0]   rsData,
	input  logic [31:0]   rtData,
	input  logic [31:0]   pc,
	input  logic [31:0]   dataRdata,
	output logic [4:0]    wrAddr,
	output logic [31:0]   wrData,
	output logic          aluZero,
	output logic [31:0]   dataAddr
);
	import cpuPkg::*;

	logic [31:0] immExt;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluRes;
	logic [7:0]  loadByte;

	assign immExt = ctrl.zeroExt ? {16'h0, instr.i.imm16}
	                             : {{16{instr.i.imm16[15]}}, instr.i.imm16};

	assign opA = (ctrl.aluSrc1 == src1Reg) ? rsData : 32'h0;

	always_comb begin
		case (ctrl.aluSrc2)
			src2Imm: opB = immExt;
			src2Pc8: opB = pc + 32'd8; // jal return address
			default: opB = rtData;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluRes = opA + opB;
			aluSub: aluRes = opA - opB;
			aluAnd: aluRes = opA & opB;
			aluOr:  aluRes = opA | opB;
			aluFunc: begin
				case (instr.r.func)
					fnAdd:  aluRes = opA + opB;
					fnSub:  aluRes = opA - opB;
					fnAnd:  aluRes = opA & opB;
					fnOr:   aluRes = opA | opB;
					fnNor:  aluRes = ~(opA | opB);
					fnSlt:  aluRes = {31'h0, $signed(opA) < $signed(opB)};
					fnSltu: aluRes = {31'h0, opA < opB};
					fnSll:  aluRes = opB << instr.r.shamt; // shifts act on rt
					fnSrl:  aluRes = opB >> instr.r.shamt;
					default: aluRes = 32'h0; // jr and unknown
				endcase
			end
			default: aluRes = 32'h0;
		endcase
	end

	assign aluZero  = (aluRes == 32'h0);
	assign dataAddr = aluRes;

	// little-endian byte lanes
	always_comb begin
		case (aluRes[1:0])
			2'd0: loadByte = dataRdata[7:0];
			2'd1: loadByte = dataRdata[15:8];
			2'd2: loadByte = dataRdata[23:16];
			default: loadByte = dataRdata[31:24];
		endcase
	end

	always_comb begin
		case (ctrl.regSrc)
			srcMem:   wrData = ctrl.byteAccess ? {24'h0, loadByte} : dataRdata;
			srcUpper: wrData = {instr.i.imm16, 16'h0};
			default:  wrData = aluRes;
		endcase
	end

	always_comb begin
		case (ctrl.regDest)
			dstRd:   wrAddr = instr.r.rd;
			dstRa:   wrAddr = regRa;
			default: wrAddr = instr.r.rt;
		endcase
	end

endmodule

/* rtl/pcUnit.sv */
`timescale 1ns/100ps

module pcUnit #(
	parameter logic [31:0] resetAddr = 32'h0
) (
	input  logic          clk,
	input  logic          rstN,
	input  cpuPkg::instrU instr,
	input  cpuPkg::ctrlT  ctrl,
	input  logic [31:0]   rsData,
	input  logic          aluZero,
	output logic [31:0]   pc
);
	import cpuPkg::*;

	logic [31:0] pcPlus4;
	logic [31:0] brOffset;
	logic        taken;
	logic [31:0] nextPc;

	assign pcPlus4  = pc + 32'd4;
	assign brOffset = {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign taken    = (ctrl.branch == brEq && aluZero) ||
	                  (ctrl.branch == brNe && !aluZero);

	always_comb begin
		case (ctrl.jump)
			jmpTarget: nextPc = {pcPlus4[31:28], instr.j.target26, 2'b00};
			jmpReg:    nextPc = rsData; // jr
			default:   nextPc = taken ? pcPlus4 + brOffset : pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetAddr;
		end else begin
			pc <= nextPc;
		end
	end

	// jr with an odd register value would break this
	assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pcUnit: misaligned pc %h", pc);

endmodule

/* rtl/cpuCore.sv */
`timescale 1ns/100ps

module cpuCore #(
	parameter logic [31:0] resetAddr = 32'h0
) (
	input  logic          clk,
	input  logic          rstN,
	output logic [31:0]   instrAddr,
	input  cpuPkg::instrU instr,
	output logic [31:0]   dataAddr,
	output logic [31:0]   dataWdata,
	output logic          dataWrite,
	output logic          dataRead,
	output logic          dataByte,
	input  logic [31:0]   dataRdata,
	output cpuPkg::wbT    wb
);
	import cpuPkg::*;

	ctrlT        ctrl;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [4:0]  wrAddr;
	logic [31:0] wrData;
	logic        aluZero;

	controlUnit uCtrl (
		.instr (instr),
		.ctrl  (ctrl)
	);

	regFile uRegs (
		.clk    (clk),
		.rstN   (rstN),
		.rsAddr (instr.r.rs),
		.rtAddr (instr.r.rt),
		.wrAddr (wrAddr),
		.wrData (wrData),
		.wrEn   (ctrl.regWrite),
		.rsData (rsData),
		.rtData (rtData)
	);

	execUnit uExec (
		.instr     (instr),
		.ctrl      (ctrl),
		.rsData    (rsData),
		.rtData    (rtData),
		.pc        (instrAddr),
		.dataRdata (dataRdata),
		.wrAddr    (wrAddr),
		.wrData    (wrData),
		.aluZero   (aluZero),
		.dataAddr  (dataAddr)
	);

	pcUnit #(
		.resetAddr (resetAddr)
	) uPc (
		.clk     (clk),
		.rstN    (rstN),
		.instr   (instr),
		.ctrl    (ctrl),
		.rsData  (rsData),
		.aluZero (aluZero),
		.pc      (instrAddr)
	);

	assign dataWdata = rtData; // sb uses the low byte
	assign dataWrite = ctrl.memWrite & rstN;
	assign dataRead  = ctrl.memRead & rstN;
	assign dataByte  = ctrl.byteAccess;

	// trace of this cycle's writeback
	assign wb.valid = ctrl.regWrite & rstN;
	assign wb.addr  = wrAddr;
	assign wb.data  = wrData;

endmodule

/* verif/isaModel.sv */
`timescale 1ns/100ps

module isaModel #(
	parameter logic [31:0] resetAddr = 32'h0
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] instrWord,
	output logic [31:0] pc,
	output cpuPkg::wbT  expWb
);
	import cpuPkg::*;

	logic [31:0] regs [32];
	logic [31:0] mem [256];
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  sh;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] zimm;
	logic [31:0] ea;
	logic [31:0] word;
	logic [31:0] seqPc;
	logic [31:0] nextPc;
	logic        doWrite;
	logic [4:0]  dest;
	logic [31:0] result;

	assign op    = instrWord[31:26];
	assign rs    = instrWord[25:21];
	assign rt    = instrWord[20:16];
	assign rd    = instrWord[15:11];
	assign sh    = instrWord[10:6];
	assign fn    = instrWord[5:0];
	assign a     = regs[rs];
	assign b     = regs[rt];
	assign simm  = {{16{instrWord[15]}}, instrWord[15:0]};
	assign zimm  = {16'h0, instrWord[15:0]};
	assign ea    = a + simm; // load/store address
	assign word  = mem[ea[9:2]];
	assign seqPc = pc + 32'd4;

	always_comb begin
		doWrite = 1'b0;
		dest    = rt;
		result  = 32'h0;
		nextPc  = seqPc;
		case (op)
			opRtype: begin
				doWrite = 1'b1;
				dest    = rd;
				case (fn)
					fnAdd:  result = a + b;
					fnSub:  result = a - b;
					fnAnd:  result = a & b;
					fnOr:   result = a | b;
					fnNor:  result = ~(a | b);
					fnSlt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fnSltu: result = (a < b) ? 32'd1 : 32'd0;
					fnSll:  result = b << sh;
					fnSrl:  result = b >> sh;
					fnJr: begin
						doWrite = 1'b0;
						nextPc  = a;
					end
					default: doWrite = 1'b0;
				endcase
			end
			opJ:   nextPc = {seqPc[31:28], instrWord[25:0], 2'b00};
			opJal: begin
				doWrite = 1'b1;
				dest    = 5'd31;
				result  = pc + 32'd8; // no delay slot, so pc+4 is skipped on return
				nextPc  = {seqPc[31:28], instrWord[25:0], 2'b00};
			end
			opBeq: if (a == b) nextPc = seqPc + {simm[29:0], 2'b00};
			opBne: if (a != b) nextPc = seqPc + {simm[29:0], 2'b00};
			opAddi: begin
				doWrite = 1'b1;
				result  = a + simm;
			end
			opAndi: begin
				doWrite = 1'b1;
				result  = a & zimm;
			end
			opOri: begin
				doWrite = 1'b1;
				result  = a | zimm;
			end
			opLui: begin
				doWrite = 1'b1;
				result  = {instrWord[15:0], 16'h0};
			end
			opLw: begin
				doWrite = 1'b1;
				result  = word;
			end
			opLbu: begin
				doWrite = 1'b1;
				result  = {24'h0, word[{ea[1:0], 3'b000} +: 8]};
			end
			default: ;
		endcase
	end

	assign expWb.valid = doWrite & rstN;
	assign expWb.addr  = dest;
	assign expWb.data  = result;

	// same fill as the data memory in the testbench
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
		end
	end

	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetAddr;
			for (int i = 0; i < 32; i++) begin
				regs[i[4:0]] <= 32'h0;
			end
		end else begin
			pc <= nextPc;
			if (doWrite && dest != 5'd0) begin
				regs[dest] <= result;
			end
			if (op == opSw) begin
				mem[ea[9:2]] <= b;
			end else if (op == opSb) begin
				mem[ea[9:2]][{ea[1:0], 3'b000} +: 8] <= b[7:0]; // one lane only
			end
		end
	end

endmodule

/* verif/cpuTb.sv */
`timescale 1ns/100ps

module cpuTb;
	import cpuPkg::*;

	localparam int clkPeriod   = 40;
	localparam int resetCycles = 5;
	localparam int memWords    = 256;

	logic        clk;
	logic        rstN;
	logic [31:0] instrAddr;
	instrU       instr;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic        dataWrite;
	logic        dataRead;
	logic        dataByte;
	logic [31:0] dataRdata;
	wbT          wb;
	logic [31:0] modelPc;
	wbT          expWb;

	logic [31:0] instrMem [memWords];
	logic [31:0] dataMem [memWords];
	int          progLen;
	int          errors;
	integer      seed;
	logic        programReady;
	logic        resetHeld; // reset has been low across one full edge
	logic [31:0] haltAddr;

	cpuCore #(
		.resetAddr (32'h0)
	) dut (
		.clk       (clk),
		.rstN      (rstN),
		.instrAddr (instrAddr),
		.instr     (instr),
		.dataAddr  (dataAddr),
		.dataWdata (dataWdata),
		.dataWrite (dataWrite),
		.dataRead  (dataRead),
		.dataByte  (dataByte),
		.dataRdata (dataRdata),
		.wb        (wb)
	);

	isaModel #(
		.resetAddr (32'h0)
	) model (
		.clk       (clk),
		.rstN      (rstN),
		.instrWord (instrMem[modelPc[9:2]]),
		.pc        (modelPc),
		.expWb     (expWb)
	);

	// combinational memory ports
	assign instr     = instrMem[instrAddr[9:2]];
	assign dataRdata = dataMem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (dataWrite) begin
			if (dataByte) begin
				dataMem[dataAddr[9:2]][{dataAddr[1:0], 3'b000} +: 8] <= dataWdata[7:0];
			end else begin
				dataMem[dataAddr[9:2]] <= dataWdata;
			end
		end
	end

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] encodeR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] sh);
		return {opRtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(logic [31:0] word);
		instrMem[progLen[7:0]] = word;
		progLen++;
	endtask

	task automatic buildProgram();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immC;
		logic [15:0] immD;
		immA = 16'($random(seed)) | 16'h8000; // negative so sign extension shows
		immB = 16'($random(seed));
		immC = 16'($random(seed)) | 16'h8000;
		immD = 16'($random(seed)) | 16'h8000;
		emit(encodeI(opAddi, 5'd0, 5'd1, immA));
		emit(encodeI(opAddi, 5'd0, 5'd2, 16'hFFFB));
		emit(encodeI(opLui, 5'd0, 5'd3, immB));
		emit(encodeI(opOri, 5'd3, 5'd3, immC));
		emit(encodeI(opAndi, 5'd3, 5'd4, immD));
		emit(encodeR(fnAdd, 5'd1, 5'd2, 5'd5, 5'd0));
		emit(encodeR(fnSub, 5'd1, 5'd3, 5'd6, 5'd0));
		emit(encodeR(fnAnd, 5'd3, 5'd2, 5'd7, 5'd0));
		emit(encodeR(fnOr, 5'd1, 5'd3, 5'd8, 5'd0));
		emit(encodeR(fnNor, 5'd1, 5'd2, 5'd9, 5'd0));
		emit(encodeR(fnSlt, 5'd2, 5'd1, 5'd10, 5'd0));
		emit(encodeR(fnSltu, 5'd2, 5'd1, 5'd11, 5'd0));
		emit(encodeR(fnSll, 5'd0, 5'd3, 5'd12, 5'd7));
		emit(encodeR(fnSrl, 5'd0, 5'd3, 5'd13, 5'd9));
		emit(encodeR(fnAdd, 5'd1, 5'd2, 5'd0, 5'd0)); // write to r0
		emit(encodeR(fnOr, 5'd0, 5'd0, 5'd14, 5'd0)); // r0 must read back as zero
		emit(encodeI(opAddi, 5'd0, 5'd15, 16'h0040));
		emit(encodeI(opSw, 5'd15, 5'd3, 16'h0004));
		emit(encodeI(opSb, 5'd15, 5'd1, 16'h0009));
		emit(encodeI(opLw, 5'd15, 5'd16, 16'h0004));
		emit(encodeI(opLbu, 5'd15, 5'd17, 16'h0009));
		emit(encodeI(opLw, 5'd15, 5'd18, 16'h0008)); // word with the merged byte
		emit(encodeI(opBeq, 5'd1, 5'd1, 16'h0001)); // taken
		emit(encodeI(opAddi, 5'd0, 5'd19, 16'h0001));
		emit(encodeI(opBne, 5'd1, 5'd1, 16'h0001)); // not taken
		emit(encodeI(opBeq, 5'd1, 5'd2, 16'h0001)); // not taken
		emit(encodeI(opBne, 5'd1, 5'd2, 16'h0001)); // taken
		emit(encodeI(opAddi, 5'd0, 5'd20, 16'h0002));
		emit({opJal, 26'd33});
		emit(encodeI(opAddi, 5'd0, 5'd21, 16'h0003)); // skipped since the link is pc+8
		emit(encodeI(opAddi, 5'd0, 5'd22, 16'h0004));
		emit({opJ, 26'd35});
		emit(encodeI(opAddi, 5'd0, 5'd24, 16'h0005));
		// subroutine at word 33
		emit(encodeR(fnAdd, 5'd31, 5'd0, 5'd23, 5'd0));
		emit(encodeR(fnJr, 5'd31, 5'd0, 5'd0, 5'd0));
		haltAddr = 32'(progLen) << 2;
		emit({opJ, 26'd35}); // halt loop
	endtask

	initial begin
		rstN         = 1'b0;
		resetHeld    = 1'b0;
		errors       = 0;
		progLen      = 0;
		programReady = 1'b0;
		seed         = 32'h1971_6013;
		for (int i = 0; i < memWords; i++) begin
			instrMem[i[7:0]] = 32'h0;
			dataMem[i[7:0]]  = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
		end
		buildProgram();
		programReady = 1'b1;
		@(negedge clk);
		resetHeld = 1'b1;
		repeat (resetCycles - 1) @(negedge clk);
		rstN = 1'b1;
		while (instrAddr != haltAddr) @(negedge clk);
		repeat (3) @(negedge clk);
		$display("run complete, %0d check(s) failed", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		wait (programReady);
		#((progLen + 20 + resetCycles) * clkPeriod);
		$display("watchdog expired before the core reached its halt loop");
		$display("test failed");
		$finish;
	end

	assert property (@(posedge clk) disable iff (!rstN) instrAddr == modelPc)
		else begin
			errors++;
			$display("CHECK FAILED instrAddr dut %h model %h",
				$sampled(instrAddr), $sampled(modelPc));
		end

	assert property (@(posedge clk) disable iff (!rstN) wb.valid == expWb.valid)
		else begin
			errors++;
			$display("CHECK FAILED wb.valid dut %h model %h at pc %h",
				$sampled(wb.valid), $sampled(expWb.valid), $sampled(instrAddr));
		end

	assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> (wb.addr == expWb.addr && wb.data == expWb.data))
		else begin
			errors++;
			$display("CHECK FAILED wb.addr/wb.data dut %h/%h model %h/%h",
				$sampled(wb.addr), $sampled(wb.data), $sampled(expWb.addr),
				$sampled(expWb.data));
		end

	// strobe and size follow the store opcodes
	assert property (@(posedge clk) disable iff (!rstN)
		dataWrite == (instr[31:26] == 6'h2B || instr[31:26] == 6'h28))
		else begin
			errors++;
			$display("CHECK FAILED dataWrite %h for opcode %h",
				$sampled(dataWrite), $sampled(instr[31:26]));
		end

	assert property (@(posedge clk) disable iff (!rstN)
		dataWrite |-> dataByte == (instr[31:26] == 6'h28))
		else begin
			errors++;
			$display("CHECK FAILED dataByte %h for opcode %h",
				$sampled(dataByte), $sampled(instr[31:26]));
		end

	// read strobe follows the load opcodes
	assert property (@(posedge clk) disable iff (!rstN)
		dataRead == (instr[31:26] == 6'h12 || instr[31:26] == 6'h22))
		else begin
			errors++;
			$display("CHECK FAILED dataRead %h for opcode %h",
				$sampled(dataRead), $sampled(instr[31:26]));
		end

	assert property (@(posedge clk)
		(resetHeld && !rstN) |->
			(instrAddr == 32'h0 && !dataWrite && !dataRead && !wb.valid))
		else begin
			errors++;
			$display("CHECK FAILED in reset instrAddr %h dataWrite %h dataRead %h wb.valid %h",
				$sampled(instrAddr), $sampled(dataWrite), $sampled(dataRead),
				$sampled(wb.valid));
		end

endmodule

/* tb.f */
rtl/cpuPkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/pcUnit.sv
rtl/cpuCore.sv
verif/isaModel.sv
verif/cpuTb.sv

/* run.sh */
#!/bin/sh
# build the core and its testbench with Verilator, run, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module cpuTb -o cpuSim \
	&& ./obj_dir/cpuSim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^test passed$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
